// File: verif/rv_core_cases.txt
# T name | P word_address instruction (hex) | S address data sel (hex), in store order
# E runs the test
T alu
P 00000000 FF900093
P 00000004 00300113
P 00000008 402081B3
P 0000000C 10302023
P 00000010 4020D233
P 00000014 10402223
P 00000018 0020D2B3
P 0000001C 10502423
P 00000020 0020A333
P 00000024 10602623
P 00000028 0020B3B3
P 0000002C 10702823
P 00000030 0F00C413
P 00000034 10802A23
P 00000038 00411493
P 0000003C 10902C23
P 00000040 4010D513
P 00000044 10A02E23
P 00000048 00500013
P 0000004C 12002023
P 00000050 00946633
P 00000054 12C02223
P 00000058 002476B3
P 0000005C 12D02423
S 00000100 FFFFFFF6 f
S 00000104 FFFFFFFF f
S 00000108 1FFFFFFF f
S 0000010C 00000001 f
S 00000110 00000000 f
S 00000114 FFFFFF09 f
S 00000118 00000030 f
S 0000011C FFFFFFFC f
S 00000120 00000000 f
S 00000124 FFFFFF39 f
S 00000128 00000001 f
E
T upper
P 00000000 123450B7
P 00000004 00001117
P 00000008 10102023
P 0000000C 10202223
S 00000100 12345000 f
S 00000104 00001004 f
E
T load_store
P 00000000 FA500093
P 00000004 101000A3
P 00000008 10101323
P 0000000C 10100103
P 00000010 10104183
P 00000014 10601203
P 00000018 10605283
P 0000001C 10202823
P 00000020 10302A23
P 00000024 10402C23
P 00000028 10502E23
S 00000101 A5A5A5A5 2
S 00000106 FFA5FFA5 c
S 00000110 FFFFFFA5 f
S 00000114 000000A5 f
S 00000118 FFFFFFA5 f
S 0000011C 0000FFA5 f
E
# Stores to 0x1FC sit on paths that must be skipped.
T control
P 00000000 FFF00093
P 00000004 00100113
P 00000008 00208463
P 0000000C 10202023
P 00000010 00209463
P 00000014 1E102E23
P 00000018 0020C463
P 0000001C 1E102E23
P 00000020 0020D463
P 00000024 10102223
P 00000028 0020E463
P 0000002C 10202423
P 00000030 0020F463
P 00000034 1E102E23
P 00000038 008001EF
P 0000003C 1E102E23
P 00000040 00C18267
P 00000044 1E102E23
P 00000048 10302623
P 0000004C 10402823
S 00000100 00000001 f
S 00000104 FFFFFFFF f
S 00000108 00000001 f
S 0000010C 0000003C f
S 00000110 00000044 f
E

// File: compile.f
logic/rv_isa_pkg.sv
logic/rv_core_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_regs.sv
logic/rv_writeback.sv
logic/rv_core.sv
verif/rv_core_props.sv
verif/rv_core_tb.sv

// File: Makefile
SRCS := $(shell cat compile.f)

obj_dir/Vrv_core_tb: compile.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f compile.f

run: obj_dir/Vrv_core_tb
	./obj_dir/Vrv_core_tb | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } store_t;

    localparam string CASE_FILE = "verif/rv_core_cases.txt";
    localparam logic [31:0] LFSR_SEED = 32'h7110bfab;

    logic        clk;
    logic        reset_n;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_out;
    logic [31:0] wb_dat_in;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_ack;
    logic        wb_cyc;

    logic [31:0] mem [0:1023];
    store_t      exp_q[$];
    string       test_name;
    int          total_words;
    logic [31:0] lfsr;
    logic [1:0]  wait_cnt;
    logic        pending;

    rv_core
    #(
        .RESET_ADDR (32'h0000_0000)
    )
    rv_core_inst
    (
        .i_clk      (clk),
        .i_reset_n  (reset_n),
        .o_wb_adr   (wb_adr),
        .o_wb_dat   (wb_dat_out),
        .i_wb_dat   (wb_dat_in),
        .o_wb_sel   (wb_sel),
        .o_wb_we    (wb_we),
        .o_wb_stb   (wb_stb),
        .i_wb_ack   (wb_ack),
        .o_wb_cyc   (wb_cyc)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            report_failure($sformatf("ERROR test %s %s: expected %h actual %h",
                                     test_name, what, expected, actual));
    endtask

    task automatic check_store();
        store_t exp;
        if (exp_q.size() == 0)
            report_failure($sformatf("Unexpected store to %h in test %s", wb_adr, test_name));
        else
        begin
            exp = exp_q.pop_front();
            check_value("store address", exp.adr, wb_adr);
            check_value("store data", exp.dat, wb_dat_out);
            check_value("store sel", {28'd0, exp.sel}, {28'd0, wb_sel});
        end
    endtask

    task automatic complete_access();
        if (wb_we)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (wb_sel[i])
                    mem[wb_adr[11:2]][8*i +: 8] = wb_dat_out[8*i +: 8];
            end
            check_store();
        end
        else
        begin
            // Fetches and loads read the whole word.
            check_value("read sel", 32'h0000_000f, {28'd0, wb_sel});
            wb_dat_in = mem[wb_adr[11:2]];
        end
        wb_ack = 1'b1;
    endtask

    // Slave with 0 to 3 wait states per access.
    always @(posedge clk)
    begin
        #1;
        if (!reset_n || !(wb_cyc && wb_stb) || wb_ack)
        begin
            wb_ack = 1'b0;
            pending = 1'b0;
        end
        else
        begin
            if (!pending)
            begin
                pending = 1'b1;
                lfsr = lfsr_next(lfsr);
                wait_cnt[0] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                wait_cnt[1] = lfsr[0];
            end
            if (wait_cnt == 2'd0)
                complete_access();
            else
                wait_cnt = wait_cnt - 2'd1;
        end
    end

    task automatic count_words();
        int    fd;
        int    code;
        string line;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0)
            report_failure("Cannot open the case file");
        while (!$feof(fd))
        begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line[0] == "P")
                total_words++;
        end
        $fclose(fd);
    endtask

    task automatic handle_line(input string line);
        string       tag;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] s;
        int          n;
        tag = "";
        n = $sscanf(line, "%s", tag);
        if (n == 1 && tag == "T")
        begin
            @(posedge clk);
            #1;
            reset_n = 1'b0;
            n = $sscanf(line, "T %s", test_name);
            exp_q.delete();
            for (int i = 0; i < 1024; i++)
                mem[i] = '0;
        end
        else if (n == 1 && tag == "P")
        begin
            n = $sscanf(line, "P %h %h", a, d);
            mem[a[11:2]] = d;
        end
        else if (n == 1 && tag == "S")
        begin
            n = $sscanf(line, "S %h %h %h", a, d, s);
            exp_q.push_back('{adr: a, dat: d, sel: s[3:0]});
        end
        else if (n == 1 && tag == "E")
        begin
            repeat (8) @(posedge clk);
            #1;
            reset_n = 1'b1;
            while (exp_q.size() != 0)
                @(posedge clk);
        end
    endtask

    initial
    begin
        int    fd;
        int    code;
        string line;
        reset_n = 1'b0;
        wb_dat_in = '0;
        wb_ack = 1'b0;
        pending = 1'b0;
        wait_cnt = 2'd0;
        lfsr = LFSR_SEED;
        total_words = 0;
        test_name = "none";
        count_words();
        fd = $fopen(CASE_FILE, "r");
        while (!$feof(fd))
        begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line[0] != "#")
                handle_line(line);
        end
        $fclose(fd);
        $display("*** TEST PASSED ***");
        $finish;
    end

    // Budget of 40 cycles per program word over the whole run.
    initial
    begin
        wait (total_words != 0);
        #(total_words * 40 * 8);
        report_failure($sformatf("Timeout: test %s still waits for %0d store(s)",
                                 test_name, exp_q.size()));
    end

endmodule

`default_nettype wire

// File: verif/rv_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_props
(
    input wire                      i_clk,
    input wire                      i_reset_n,
    input wire [31:0]               i_adr,
    input wire                      i_we,
    input wire                      i_stb,
    input wire                      i_cyc,
    input wire                      i_ack,
    input wire rv_core_pkg::state_t i_state
);

    import rv_core_pkg::*;

    a_stb_cyc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_stb == i_cyc) else $error("stb and cyc differ");

    // A request holds until it is acknowledged.
    a_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_stb && !i_ack) |=> (i_stb && $stable(i_adr) && $stable(i_we)))
        else $error("bus request changed before ack");

    a_fetch_read: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_state == ST_FETCH) |-> !i_we) else $error("write during fetch");

    a_from_fetch: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_state == ST_FETCH) |=> (i_state == ST_FETCH || i_state == ST_DECODE))
        else $error("illegal state after fetch");

    a_from_decode: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_state == ST_DECODE) |=> (i_state == ST_EXEC)) else $error("illegal state after decode");

    a_from_exec: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_state == ST_EXEC) |=> (i_state == ST_MEM)) else $error("illegal state after execute");

    a_from_mem: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_state == ST_MEM) |=> (i_state == ST_MEM || i_state == ST_WB))
        else $error("illegal state after memory");

    a_from_wb: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_state == ST_WB) |=> (i_state == ST_FETCH)) else $error("illegal state after writeback");

endmodule

bind rv_core rv_core_props props_inst
(
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_adr      (o_wb_adr),
    .i_we       (o_wb_we),
    .i_stb      (o_wb_stb),
    .i_cyc      (o_wb_cyc),
    .i_ack      (i_wb_ack),
    .i_state    (state)
);

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
)
(
    input  wire         i_clk,
    input  wire         i_reset_n,
    output logic [31:0] o_wb_adr,
    output logic [31:0] o_wb_dat,
    input  wire  [31:0] i_wb_dat,
    output logic [3:0]  o_wb_sel,
    output logic        o_wb_we,
    output logic        o_wb_stb,
    input  wire         i_wb_ack,
    output logic        o_wb_cyc
);

    import rv_core_pkg::*;

    state_t      state, state_nxt;
    logic        running, fetch_req, mem_op, bus_data, fetch_latch, mem_latch, reg_wr;
    logic [31:0] pc, rdata1, rdata2, wb_data;
    logic [4:0]  rs1, rs2, wb_rd;
    fetch_bus_t  fetch_bus;
    decode_bus_t decode_bus;
    exec_bus_t   exec_bus;

    // Holds the bus idle through the reset cycle.
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            running <= 1'b0;
        else
            running <= 1'b1;
    end

    assign fetch_req = (state == ST_FETCH) & running;
    assign mem_op = exec_bus.is_load | exec_bus.is_store;
    assign bus_data = (state == ST_MEM) & mem_op;
    assign fetch_latch = fetch_req & i_wb_ack;
    assign mem_latch = bus_data & i_wb_ack;
    assign reg_wr = (state == ST_WB) & exec_bus.reg_write;

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_FETCH:  state_nxt = fetch_latch ? ST_DECODE : ST_FETCH;
            ST_DECODE: state_nxt = ST_EXEC;
            ST_EXEC:   state_nxt = ST_MEM;
            ST_MEM:    state_nxt = (!mem_op || i_wb_ack) ? ST_WB : ST_MEM;
            ST_WB:     state_nxt = ST_FETCH;
            default:   state_nxt = ST_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            state <= ST_FETCH;
        else
            state <= state_nxt;
    end

    // Data phase owns the bus only in ST_MEM.
    assign o_wb_adr = bus_data ? exec_bus.alu_result : pc;
    assign o_wb_dat = exec_bus.wdata;
    assign o_wb_we = bus_data & exec_bus.is_store;
    assign o_wb_sel = (bus_data & exec_bus.is_store) ? exec_bus.wsel : 4'b1111;
    assign o_wb_cyc = fetch_req | bus_data;
    assign o_wb_stb = fetch_req | bus_data;

    rv_fetch
    #(
        .RESET_ADDR (RESET_ADDR)
    )
    u_fetch
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_latch    (fetch_latch),
        .i_advance  (state == ST_WB),
        .i_instr    (i_wb_dat),
        .i_exec     (exec_bus),
        .o_pc       (pc),
        .o_bus      (fetch_bus)
    );

    rv_decode
    u_decode
    (
        .i_clk      (i_clk),
        .i_bus      (fetch_bus),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .o_bus      (decode_bus)
    );

    rv_regs
    u_regs
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rd       (wb_rd),
        .i_write    (reg_wr),
        .i_data     (wb_data),
        .o_data1    (rdata1),
        .o_data2    (rdata2)
    );

    rv_execute
    u_execute
    (
        .i_clk      (i_clk),
        .i_bus      (decode_bus),
        .i_rdata1   (rdata1),
        .i_rdata2   (rdata2),
        .o_bus      (exec_bus)
    );

    rv_writeback
    u_writeback
    (
        .i_clk      (i_clk),
        .i_latch    (mem_latch),
        .i_bus      (exec_bus),
        .i_data     (i_wb_dat),
        .o_rd       (wb_rd),
        .o_data     (wb_data)
    );

endmodule

`default_nettype wire

// File: logic/rv_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module rv_writeback
(
    input  wire                      i_clk,
    input  wire                      i_latch,
    input  wire rv_core_pkg::exec_bus_t i_bus,
    input  wire [31:0]               i_data,
    output logic [4:0]               o_rd,
    output logic [31:0]              o_data
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [31:0] load_word, load_val;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    always_ff @(posedge i_clk)
    begin
        if (i_latch)
            load_word <= i_data;
    end

    // Low address bits pick the lane.
    assign lane_b = load_word[{i_bus.alu_result[1:0], 3'b000} +: 8];
    assign lane_h = i_bus.alu_result[1] ? load_word[31:16] : load_word[15:0];

    always_comb
    begin
        case (i_bus.funct3)
            F3_B:    load_val = {{24{lane_b[7]}}, lane_b};
            F3_H:    load_val = {{16{lane_h[15]}}, lane_h};
            F3_BU:   load_val = {24'd0, lane_b};
            F3_HU:   load_val = {16'd0, lane_h};
            default: load_val = load_word;
        endcase
    end

    always_comb
    begin
        case (i_bus.res_src)
            RES_MEM: o_data = load_val;
            RES_PC4: o_data = i_bus.pc_p4;
            default: o_data = i_bus.alu_result;
        endcase
    end

    assign o_rd = i_bus.rd;

endmodule

`default_nettype wire

// File: logic/rv_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regs
(
    input  wire        i_clk,
    input  wire        i_reset_n,
    input  wire [4:0]  i_rs1,
    input  wire [4:0]  i_rs2,
    input  wire [4:0]  i_rd,
    input  wire        i_write,
    input  wire [31:0] i_data,
    output logic [31:0] o_data1,
    output logic [31:0] o_data2
);

    // x0 has no storage.
    logic [31:0] regs [1:31];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_write && i_rd != 5'd0)
            regs[i_rd] <= i_data;
    end

    assign o_data1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_data2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute
(
    input  wire                        i_clk,
    input  wire rv_core_pkg::decode_bus_t i_bus,
    input  wire [31:0]                 i_rdata1,
    input  wire [31:0]                 i_rdata2,
    output rv_core_pkg::exec_bus_t     o_bus
);

    import rv_isa_pkg::*;

    logic [31:0] op_a, op_b, result, jalr_sum, wdata;
    logic [3:0]  wsel;
    logic        taken;

    assign op_a = i_bus.a_is_pc ? i_bus.pc : i_rdata1;
    assign op_b = i_bus.b_is_imm ? i_bus.imm : i_rdata2;
    assign jalr_sum = i_rdata1 + i_bus.imm;

    always_comb
    begin
        case (i_bus.alu_op)
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << op_b[4:0];
            ALU_SLT:  result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'd0, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> op_b[4:0];
            ALU_SRA:  result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = op_a + op_b;
        endcase
    end

    // Branches compare the raw register values.
    always_comb
    begin
        case (i_bus.funct3)
            F3_BEQ:  taken = i_rdata1 == i_rdata2;
            F3_BNE:  taken = i_rdata1 != i_rdata2;
            F3_BLT:  taken = $signed(i_rdata1) < $signed(i_rdata2);
            F3_BGE:  taken = $signed(i_rdata1) >= $signed(i_rdata2);
            F3_BLTU: taken = i_rdata1 < i_rdata2;
            F3_BGEU: taken = i_rdata1 >= i_rdata2;
            default: taken = 1'b0;
        endcase
    end

    // Store data is replicated across lanes and sel picks the addressed lane.
    always_comb
    begin
        case (i_bus.funct3)
            F3_B:
            begin
                wdata = {4{i_rdata2[7:0]}};
                wsel = 4'b0001 << result[1:0];
            end
            F3_H:
            begin
                wdata = {2{i_rdata2[15:0]}};
                wsel = result[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                wdata = i_rdata2;
                wsel = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        o_bus.alu_result <= result;
        o_bus.pc_p4 <= i_bus.pc + 32'd4;
        o_bus.pc_target <= i_bus.is_jalr ? {jalr_sum[31:1], 1'b0} : i_bus.pc + i_bus.imm;
        o_bus.pc_select <= i_bus.is_jal | i_bus.is_jalr | (i_bus.is_branch & taken);
        o_bus.rd <= i_bus.rd;
        o_bus.funct3 <= i_bus.funct3;
        o_bus.reg_write <= i_bus.reg_write;
        o_bus.res_src <= i_bus.res_src;
        o_bus.is_load <= i_bus.is_load;
        o_bus.is_store <= i_bus.is_store;
        o_bus.wdata <= wdata;
        o_bus.wsel <= wsel;
    end

endmodule

`default_nettype wire

// File: logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
(
    input  wire                       i_clk,
    input  wire rv_core_pkg::fetch_bus_t i_bus,
    output logic [4:0]                o_rs1,
    output logic [4:0]                o_rs2,
    output rv_core_pkg::decode_bus_t  o_bus
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    instr_t      instr;
    decode_bus_t dec;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  alu_sel = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  alu_sel = ALU_SLL;
            F3_SLT:  alu_sel = ALU_SLT;
            F3_SLTU: alu_sel = ALU_SLTU;
            F3_XOR:  alu_sel = ALU_XOR;
            F3_SR:   alu_sel = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    assign instr = i_bus.instr;

    assign imm_i = {{20{instr.r_view.funct7[6]}}, instr.r_view.funct7, instr.r_view.rs2};
    assign imm_s = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi, instr.s_view.imm_lo};
    assign imm_b = {{19{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi[6], instr.s_view.imm_lo[0],
                    instr.s_view.imm_hi[5:0], instr.s_view.imm_lo[4:1], 1'b0};
    assign imm_u = {instr.r_view.funct7, instr.r_view.rs2, instr.r_view.rs1,
                    instr.r_view.funct3, 12'h000};
    assign imm_j = {{11{instr.r_view.funct7[6]}}, instr.r_view.funct7[6], instr.r_view.rs1,
                    instr.r_view.funct3, instr.r_view.rs2[0], instr.r_view.funct7[5:0],
                    instr.r_view.rs2[4:1], 1'b0};

    always_comb
    begin
        dec = '0;
        dec.pc = i_bus.pc;
        dec.rs1 = instr.r_view.rs1;
        dec.rs2 = instr.r_view.rs2;
        dec.rd = instr.r_view.rd;
        dec.funct3 = instr.r_view.funct3;
        dec.alu_op = ALU_ADD;
        dec.res_src = RES_ALU;
        case (instr.r_view.opcode)
            OPC_LUI:
            begin
                // rs1 forced to x0 so the ALU adds to zero.
                dec.rs1 = 5'd0;
                dec.imm = imm_u;
                dec.b_is_imm = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_AUIPC:
            begin
                dec.imm = imm_u;
                dec.a_is_pc = 1'b1;
                dec.b_is_imm = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_JAL:
            begin
                dec.imm = imm_j;
                dec.is_jal = 1'b1;
                dec.reg_write = 1'b1;
                dec.res_src = RES_PC4;
            end
            OPC_JALR:
            begin
                dec.imm = imm_i;
                dec.is_jalr = 1'b1;
                dec.reg_write = 1'b1;
                dec.res_src = RES_PC4;
            end
            OPC_BRANCH:
            begin
                dec.imm = imm_b;
                dec.is_branch = 1'b1;
            end
            OPC_LOAD:
            begin
                dec.imm = imm_i;
                dec.b_is_imm = 1'b1;
                dec.is_load = 1'b1;
                dec.reg_write = 1'b1;
                dec.res_src = RES_MEM;
            end
            OPC_STORE:
            begin
                dec.imm = imm_s;
                dec.b_is_imm = 1'b1;
                dec.is_store = 1'b1;
            end
            OPC_OPIMM:
            begin
                dec.imm = imm_i;
                dec.b_is_imm = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_op = alu_sel(instr.r_view.funct3,
                                     instr.r_view.funct7[5] && instr.r_view.funct3 == F3_SR);
            end
            OPC_OP:
            begin
                dec.reg_write = 1'b1;
                dec.alu_op = alu_sel(instr.r_view.funct3, instr.r_view.funct7[5]);
            end
            default:
                ; // Fences and unknown opcodes fall through as no-ops.
        endcase
    end

    assign o_rs1 = dec.rs1;
    assign o_rs2 = dec.rs2;

    always_ff @(posedge i_clk)
    begin
        o_bus <= dec;
    end

endmodule

`default_nettype wire

// File: logic/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
)
(
    input  wire                     i_clk,
    input  wire                     i_reset_n,
    input  wire                     i_latch,
    input  wire                     i_advance,
    input  wire [31:0]              i_instr,
    input  wire rv_core_pkg::exec_bus_t i_exec,
    output logic [31:0]             o_pc,
    output rv_core_pkg::fetch_bus_t o_bus
);

    logic [31:0] pc;
    logic [31:0] instr;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= RESET_ADDR;
        else if (i_advance)
            pc <= i_exec.pc_select ? i_exec.pc_target : i_exec.pc_p4;
    end

    // Instruction word is captured on the fetch ack.
    always_ff @(posedge i_clk)
    begin
        if (i_latch)
            instr <= i_instr;
    end

    assign o_pc = pc;
    assign o_bus.pc = pc;
    assign o_bus.instr = instr;

endmodule

`default_nettype wire

// File: logic/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_MEM,
        ST_WB
    } state_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } res_src_t;

    typedef struct packed {
        logic [31:0]        pc;
        rv_isa_pkg::instr_t instr;
    } fetch_bus_t;

    typedef struct packed {
        logic [31:0]         pc;
        logic [31:0]         imm;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [2:0]          funct3;
        rv_isa_pkg::alu_op_t alu_op;
        logic                a_is_pc;
        logic                b_is_imm;
        logic                is_branch;
        logic                is_jal;
        logic                is_jalr;
        logic                is_load;
        logic                is_store;
        logic                reg_write;
        res_src_t            res_src;
    } decode_bus_t;

    typedef struct packed {
        logic [31:0] alu_result;
        logic [31:0] pc_p4;
        logic [31:0] pc_target;
        logic        pc_select;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic        reg_write;
        res_src_t    res_src;
        logic        is_load;
        logic        is_store;
        logic [31:0] wdata;
        logic [3:0]  wsel;
    } exec_bus_t;

endpackage

`default_nettype wire

// File: logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes, instruction bits [6:0].
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ALU funct3.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch funct3.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store width funct3.
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    // Stores and branches split their immediate around rs1/rs2.
    typedef union packed {
        r_view_t r_view;
        s_view_t s_view;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

endpackage

`default_nettype wire
